// File: systolic_mm.f
+incdir+tests
common/systolic_pkg.sv
common/operand_if.sv
logic/apb_regs.sv
feeder/operand_skewer.sv
pe_array/pe_mac.sv
pe_array/pe_grid.sv
logic/result_drain.sv
systolic_mm_top.sv
tests/tb_systolic_mm.sv

// File: tests/mm_model.svh
//##############################
// APB3 bus tasks and the matrix product model
// included inside tb_systolic_mm, uses its clk and APB signals
// one access takes three cycles including an idle cycle
// outputs are sampled at the falling edge of the access phase
//##############################
`ifndef MM_MODEL_SVH
`define MM_MODEL_SVH

// byte address of element (row, col), row-major, one word each
function automatic systolic_pkg::apb_addr_t elem_addr(
    input systolic_pkg::apb_addr_t base,
    input int row,
    input int col
);
    return base + systolic_pkg::apb_addr_t'((row * systolic_pkg::array_n + col) * 4);
endfunction

// C = A x B, every product and sum wraps at 16 bits
function automatic systolic_pkg::matrix_t model_product(
    input systolic_pkg::matrix_t a,
    input systolic_pkg::matrix_t b
);
    systolic_pkg::matrix_t c;
    systolic_pkg::data_t acc;
    for (int i = 0; i < systolic_pkg::array_n; i++) begin
        for (int j = 0; j < systolic_pkg::array_n; j++) begin
            acc = '0;
            for (int k = 0; k < systolic_pkg::array_n; k++) begin
                acc = acc + systolic_pkg::data_t'(a[i][k] * b[k][j]);
            end
            c[i][j] = acc;
        end
    end
    return c;
endfunction

task automatic apb_write(
    input  systolic_pkg::apb_addr_t addr,
    input  logic [31:0]             data,
    output logic                    slverr
);
    @(posedge clk);
    #drive_delay;
    paddr   = addr;
    pwdata  = data;
    pwrite  = 1'b1;
    psel    = 1'b1;
    penable = 1'b0;
    @(posedge clk);
    #drive_delay;
    penable = 1'b1;
    @(negedge clk);
    slverr = pslverr;
    if (pready !== 1'b1) begin
        abort_run("pready was low during a write access, no wait states are expected");
    end
    @(posedge clk);
    #drive_delay;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
endtask

task automatic apb_read(
    input  systolic_pkg::apb_addr_t addr,
    output logic [31:0]             data,
    output logic                    slverr
);
    @(posedge clk);
    #drive_delay;
    paddr   = addr;
    pwrite  = 1'b0;
    psel    = 1'b1;
    penable = 1'b0;
    @(posedge clk);
    #drive_delay;
    penable = 1'b1;
    @(negedge clk);
    data   = prdata;
    slverr = pslverr;
    if (pready !== 1'b1) begin
        abort_run("pready was low during a read access, no wait states are expected");
    end
    @(posedge clk);
    #drive_delay;
    psel    = 1'b0;
    penable = 1'b0;
endtask

`endif

// File: tests/tb_systolic_mm.sv
//##############################
// testbench for the APB systolic matrix multiplier
// random matrices from a fixed seed, checked against a model
// inputs change 1 ns after the rising edge
// the run stops at the first mismatch
//##############################
`timescale 1ns/1ps
`default_nettype none

module tb_systolic_mm;

    localparam int clk_period  = 100;
    localparam int drive_delay = 1;
    localparam int num_runs    = 10;
    localparam int poll_limit  = 100;
    // three cycles per access, about 60 accesses per run
    localparam int access_cycles    = 3;
    localparam int accesses_per_run = 60;
    localparam int watchdog_cycles  =
        (num_runs + 2) * (accesses_per_run * access_cycles + poll_limit) * 2;

    logic                    clk;
    logic                    sys_rst;
    systolic_pkg::apb_addr_t paddr;
    logic                    psel;
    logic                    penable;
    logic                    pwrite;
    logic [31:0]             pwdata;
    logic [31:0]             prdata;
    logic                    pready;
    logic                    pslverr;

    systolic_mm_top systolic_mm_top_inst (
        .clk     (clk),
        .sys_rst (sys_rst),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    always #(clk_period / 2) clk = ~clk;

    task automatic report_mismatch(input string msg);
        $display("FAILED at %0d ns: %s", $time, msg);
        $display("CHECKS FAILED");
        $fatal(1, "stopped at the first mismatch");
    endtask

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("CHECKS FAILED");
        $fatal(1, "run aborted");
    endtask

    `include "mm_model.svh"

    task automatic check_word(
        input string               what,
        input systolic_pkg::data_t got,
        input systolic_pkg::data_t exp
    );
        if (got !== exp) begin
            report_mismatch($sformatf("%s got %h expected %h", what, got, exp));
        end
    endtask

    task automatic check_status(
        input string what,
        input logic  got_busy,
        input logic  got_done,
        input logic  exp_busy,
        input logic  exp_done
    );
        if (got_busy !== exp_busy || got_done !== exp_done) begin
            report_mismatch($sformatf("%s busy/done got %b%b expected %b%b",
                what, got_busy, got_done, exp_busy, exp_done));
        end
    endtask

    task automatic check_slverr(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            report_mismatch($sformatf("%s pslverr got %b expected %b", what, got, exp));
        end
    endtask

    function automatic systolic_pkg::matrix_t random_matrix();
        systolic_pkg::matrix_t m;
        for (int i = 0; i < systolic_pkg::array_n; i++) begin
            for (int j = 0; j < systolic_pkg::array_n; j++) begin
                m[i][j] = systolic_pkg::data_t'($urandom);
            end
        end
        return m;
    endfunction

    task automatic load_matrix(input systolic_pkg::apb_addr_t base, input systolic_pkg::matrix_t m);
        logic err;
        for (int i = 0; i < systolic_pkg::array_n; i++) begin
            for (int j = 0; j < systolic_pkg::array_n; j++) begin
                apb_write(elem_addr(base, i, j), {16'h0000, m[i][j]}, err);
                check_slverr("matrix write", err, 1'b0);
            end
        end
    endtask

    task automatic verify_c(input systolic_pkg::matrix_t exp);
        logic [31:0] rdata;
        logic        err;
        for (int i = 0; i < systolic_pkg::array_n; i++) begin
            for (int j = 0; j < systolic_pkg::array_n; j++) begin
                apb_read(elem_addr(systolic_pkg::c_base, i, j), rdata, err);
                check_slverr("C read", err, 1'b0);
                check_word($sformatf("C[%0d][%0d]", i, j), rdata[15:0], exp[i][j]);
                check_word("C upper half", rdata[31:16], '0);
            end
        end
    endtask

    task automatic wait_done();
        logic [31:0] rdata;
        logic        err;
        logic        finished;
        int          polls;
        finished = 1'b0;
        polls    = 0;
        while (!finished && polls < poll_limit) begin
            apb_read(systolic_pkg::status_addr, rdata, err);
            check_slverr("status poll", err, 1'b0);
            if (rdata[1]) begin
                finished = 1'b1;
            end else begin
                check_status("status while running", rdata[0], rdata[1], 1'b1, 1'b0);
            end
            polls++;
        end
        if (!finished) begin
            abort_run("status poll gave up, done never rose within the poll limit");
        end else begin
            check_status("status at completion", rdata[0], rdata[1], 1'b0, 1'b1);
        end
    endtask

    // every write here must be refused while the array runs
    task automatic busy_writes(
        input systolic_pkg::matrix_t a,
        input systolic_pkg::matrix_t b
    );
        logic [31:0] rdata;
        logic        err;
        int          ar;
        int          ac;
        int          br;
        int          bc;
        ar = $urandom % 4;
        ac = $urandom % 4;
        br = $urandom % 4;
        bc = $urandom % 4;
        apb_write(elem_addr(systolic_pkg::a_base, ar, ac), {16'h0000, ~a[ar][ac]}, err);
        check_slverr("A write while busy", err, 1'b1);
        apb_write(elem_addr(systolic_pkg::b_base, br, bc), {16'h0000, ~b[br][bc]}, err);
        check_slverr("B write while busy", err, 1'b1);
        apb_write(systolic_pkg::ctrl_addr, 32'h1, err);
        check_slverr("ctrl write while busy", err, 1'b1);
        // stored operands keep the values written before start
        apb_read(elem_addr(systolic_pkg::a_base, ar, ac), rdata, err);
        check_word("A after refused write", rdata[15:0], a[ar][ac]);
        apb_read(elem_addr(systolic_pkg::b_base, br, bc), rdata, err);
        check_word("B after refused write", rdata[15:0], b[br][bc]);
    endtask

    task automatic run_product(input systolic_pkg::matrix_t a, input systolic_pkg::matrix_t b);
        logic [31:0] rdata;
        logic        err;
        load_matrix(systolic_pkg::a_base, a);
        load_matrix(systolic_pkg::b_base, b);
        apb_write(systolic_pkg::ctrl_addr, 32'h1, err);
        check_slverr("start write", err, 1'b0);
        // done from the previous run must be gone
        apb_read(systolic_pkg::status_addr, rdata, err);
        check_slverr("status after start", err, 1'b0);
        check_status("status after start", rdata[0], rdata[1], 1'b1, 1'b0);
        busy_writes(a, b);
        wait_done();
        verify_c(model_product(a, b));
    endtask

    task automatic illegal_accesses(input systolic_pkg::matrix_t exp);
        logic [31:0] rdata;
        logic        err;
        apb_write(elem_addr(systolic_pkg::c_base, 1, 2), $urandom, err);
        check_slverr("write to C", err, 1'b1);
        apb_write(systolic_pkg::status_addr, 32'h3, err);
        check_slverr("write to status", err, 1'b1);
        apb_write(12'h0C8, $urandom, err);
        check_slverr("unmapped write", err, 1'b1);
        apb_read(12'h100, rdata, err);
        check_slverr("unmapped read", err, 1'b1);
        check_word("unmapped read low", rdata[15:0], '0);
        check_word("unmapped read high", rdata[31:16], '0);
        apb_read(12'h002, rdata, err);
        check_slverr("unaligned read", err, 1'b1);
        check_word("unaligned read low", rdata[15:0], '0);
        verify_c(exp);
        apb_read(systolic_pkg::status_addr, rdata, err);
        check_status("status after illegal accesses", rdata[0], rdata[1], 1'b0, 1'b1);
    endtask

    initial begin
        #(watchdog_cycles * clk_period);
        abort_run("watchdog expired, the test did not finish in the expected time");
    end

    initial begin
        logic [31:0]           rdata;
        logic                  err;
        systolic_pkg::matrix_t a;
        systolic_pkg::matrix_t b;
        void'($urandom(32'h7dfbee5a));
        clk      = 1'b0;
        sys_rst  = 1'b1;
        paddr    = '0;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        pwdata   = '0;
        repeat (5) @(posedge clk);
        #drive_delay;
        sys_rst = 1'b0;

        apb_read(systolic_pkg::status_addr, rdata, err);
        check_slverr("status after reset", err, 1'b0);
        check_status("status after reset", rdata[0], rdata[1], 1'b0, 1'b0);
        verify_c('0);

        // run 4 is all zeros, run 7 all ones for wraparound
        for (int run = 0; run < num_runs; run++) begin
            if (run == 4) begin
                a = '0;
                b = '0;
            end else if (run == 7) begin
                a = '1;
                b = '1;
            end else begin
                a = random_matrix();
                b = random_matrix();
            end
            run_product(a, b);
            if (run == 0) begin
                illegal_accesses(model_product(a, b));
            end
        end

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: systolic_mm_top.sv
//##############################
// 4 by 4 systolic matrix multiplier behind APB3
// no wait states, no interrupt, host polls status
//##############################
`timescale 1ns/1ps
`default_nettype none

module systolic_mm_top (
    input  wire logic                    clk,
    input  wire logic                    sys_rst,
    input  wire systolic_pkg::apb_addr_t paddr,
    input  wire logic                    psel,
    input  wire logic                    penable,
    input  wire logic                    pwrite,
    input  wire logic [31:0]             pwdata,
    output logic [31:0]                  prdata,
    output logic                         pready,
    output logic                         pslverr
);

    systolic_pkg::matrix_t mat_a;
    systolic_pkg::matrix_t mat_b;
    systolic_pkg::matrix_t mat_c;
    logic                  start;
    logic                  run_done;
    wire [systolic_pkg::array_n-1:0]                res_valid;
    systolic_pkg::data_t [systolic_pkg::array_n-1:0] res_data;

    operand_if feed_if ();

    apb_regs apb_regs_inst (
        .clk      (clk),
        .sys_rst  (sys_rst),
        .paddr    (paddr),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .mat_a    (mat_a),
        .mat_b    (mat_b),
        .mat_c    (mat_c),
        .start    (start),
        .run_done (run_done)
    );

    operand_skewer operand_skewer_inst (
        .clk     (clk),
        .sys_rst (sys_rst),
        .start   (start),
        .mat_a   (mat_a),
        .mat_b   (mat_b),
        .feed    (feed_if.src)
    );

    pe_grid pe_grid_inst (
        .clk       (clk),
        .sys_rst   (sys_rst),
        .feed      (feed_if.sink),
        .res_valid (res_valid),
        .res_data  (res_data)
    );

    result_drain result_drain_inst (
        .clk       (clk),
        .sys_rst   (sys_rst),
        .res_valid (res_valid),
        .res_data  (res_data),
        .start     (start),
        .mat_c     (mat_c),
        .run_done  (run_done)
    );

endmodule

`default_nettype wire

// File: logic/result_drain.sv
//##############################
// stores the west-edge result stream into C
// each row delivers its results in column order
// C holds the last run until overwritten
//##############################
`timescale 1ns/1ps
`default_nettype none

module result_drain (
    input  wire logic                                           clk,
    input  wire logic                                           sys_rst,
    input  wire logic [systolic_pkg::array_n-1:0]               res_valid,
    input  wire systolic_pkg::data_t [systolic_pkg::array_n-1:0] res_data,
    input  wire logic                                           start,
    output systolic_pkg::matrix_t                               mat_c,
    output logic                                                run_done
);

    systolic_pkg::idx_t col_cnt [systolic_pkg::array_n];
    logic [$clog2(systolic_pkg::array_n*systolic_pkg::array_n):0] total;
    logic [$clog2(systolic_pkg::array_n*systolic_pkg::array_n):0] total_next;

    // several rows can deliver in the same cycle
    always_comb begin
        total_next = total;
        for (int i = 0; i < systolic_pkg::array_n; i++) begin
            total_next = total_next + res_valid[i];
        end
    end

    always_ff @(posedge clk) begin
        if (sys_rst || start) begin
            total    <= '0;
            run_done <= 1'b0;
            for (int i = 0; i < systolic_pkg::array_n; i++) begin
                col_cnt[i] <= '0;
            end
        end else begin
            total    <= total_next;
            run_done <= (total != systolic_pkg::array_n * systolic_pkg::array_n) &&
                        (total_next == systolic_pkg::array_n * systolic_pkg::array_n);
            for (int i = 0; i < systolic_pkg::array_n; i++) begin
                if (res_valid[i]) begin
                    col_cnt[i] <= col_cnt[i] + 1'b1;
                end
            end
        end
    end

    // C reads zero after reset
    always_ff @(posedge clk) begin
        if (sys_rst) begin
            mat_c <= '0;
        end else begin
            for (int i = 0; i < systolic_pkg::array_n; i++) begin
                if (res_valid[i]) begin
                    mat_c[i][col_cnt[i]] <= res_data[i];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: pe_array/pe_grid.sv
//##############################
// array_n by array_n mesh of pe_mac elements
// north and west edges fed from the operand interface
// results leave through the west-most column
//##############################
`timescale 1ns/1ps
`default_nettype none

module pe_grid (
    input  wire logic                                      clk,
    input  wire logic                                      sys_rst,
    operand_if.sink                                        feed,
    output wire [systolic_pkg::array_n-1:0]                res_valid,
    output systolic_pkg::data_t [systolic_pkg::array_n-1:0] res_data
);

    // vertical links carry one extra row, horizontal ones an extra column
    wire                      en_v   [systolic_pkg::array_n+1][systolic_pkg::array_n];
    wire                      done_v [systolic_pkg::array_n+1][systolic_pkg::array_n];
    wire systolic_pkg::data_t data_v [systolic_pkg::array_n+1][systolic_pkg::array_n];
    wire systolic_pkg::data_t data_h [systolic_pkg::array_n][systolic_pkg::array_n+1];
    wire                      rval_h [systolic_pkg::array_n][systolic_pkg::array_n+1];
    wire systolic_pkg::data_t res_h  [systolic_pkg::array_n][systolic_pkg::array_n+1];

    genvar r;
    genvar c;

    generate
        for (c = 0; c < systolic_pkg::array_n; c++) begin : g_north
            assign en_v[0][c]   = feed.cal_en[c];
            assign done_v[0][c] = feed.cal_done[c];
            assign data_v[0][c] = feed.v_data[c];
        end

        for (r = 0; r < systolic_pkg::array_n; r++) begin : g_row
            assign data_h[r][0] = feed.h_data[r];
            // nothing arrives from beyond the east edge
            assign rval_h[r][systolic_pkg::array_n] = 1'b0;
            assign res_h[r][systolic_pkg::array_n]  = '0;
            assign res_valid[r] = rval_h[r][0];
            assign res_data[r]  = res_h[r][0];

            for (c = 0; c < systolic_pkg::array_n; c++) begin : g_col
                pe_mac pe_mac_inst (
                    .clk        (clk),
                    .sys_rst    (sys_rst),
                    .cal_en_n   (en_v[r][c]),
                    .cal_done_n (done_v[r][c]),
                    .cal_en_s   (en_v[r+1][c]),
                    .cal_done_s (done_v[r+1][c]),
                    .v_data_n   (data_v[r][c]),
                    .v_data_s   (data_v[r+1][c]),
                    .h_data_w   (data_h[r][c]),
                    .h_data_e   (data_h[r][c+1]),
                    .res_val_e  (rval_h[r][c+1]),
                    .res_e      (res_h[r][c+1]),
                    .res_val_w  (rval_h[r][c]),
                    .res_w      (res_h[r][c])
                );
            end
        end
    endgenerate

endmodule

`default_nettype wire

// File: pe_array/pe_mac.sv
//##############################
// output-stationary multiply-accumulate element
// operands flow north to south and west to east
// results flow east to west, one hop per cycle
// products and sums wrap at data_w bits
//##############################
`timescale 1ns/1ps
`default_nettype none

module pe_mac (
    input  wire logic                clk,
    input  wire logic                sys_rst,
    input  wire logic                cal_en_n,
    input  wire logic                cal_done_n,
    output logic                     cal_en_s,
    output logic                     cal_done_s,
    input  wire systolic_pkg::data_t v_data_n,
    output systolic_pkg::data_t      v_data_s,
    input  wire systolic_pkg::data_t h_data_w,
    output systolic_pkg::data_t      h_data_e,
    input  wire logic                res_val_e,
    input  wire systolic_pkg::data_t res_e,
    output logic                     res_val_w,
    output systolic_pkg::data_t      res_w
);

    systolic_pkg::data_t product;
    systolic_pkg::data_t partial_sum;

    always_ff @(posedge clk) begin
        if (sys_rst) begin
            cal_en_s   <= 1'b0;
            cal_done_s <= 1'b0;
            res_val_w  <= 1'b0;
        end else begin
            cal_en_s   <= cal_en_n;
            cal_done_s <= cal_done_n;
            res_val_w  <= cal_done_n || res_val_e;
        end
    end

    // operands only pass while enabled, zero otherwise
    always_ff @(posedge clk) begin
        if (cal_en_n) begin
            v_data_s <= v_data_n;
            h_data_e <= h_data_w;
            product  <= h_data_w * v_data_n;
        end else begin
            v_data_s <= '0;
            h_data_e <= '0;
            product  <= '0;
        end
    end

    // product lags one cycle, so the last one is added on cal_done
    always_ff @(posedge clk) begin
        if (cal_en_n) begin
            partial_sum <= partial_sum + product;
        end else begin
            partial_sum <= '0;
        end
    end

    // own result wins over the relay, they never coincide
    always_ff @(posedge clk) begin
        if (cal_done_n) begin
            res_w <= partial_sum + product;
        end else if (res_val_e) begin
            res_w <= res_e;
        end else begin
            res_w <= '0;
        end
    end

endmodule

`default_nettype wire

// File: feeder/operand_skewer.sv
//##############################
// streams A rows west and B columns north with a diagonal skew
// eight cycles per run, four feeding and four flushing
// A and B must stay stable until the run ends
//##############################
`timescale 1ns/1ps
`default_nettype none

module operand_skewer (
    input  wire logic                  clk,
    input  wire logic                  sys_rst,
    input  wire logic                  start,
    input  wire systolic_pkg::matrix_t mat_a,
    input  wire systolic_pkg::matrix_t mat_b,
    operand_if.src                     feed
);

    systolic_pkg::feed_state_t state;
    systolic_pkg::idx_t        step;
    logic [2:0]                t;
    logic                      active;

    always_ff @(posedge clk) begin
        if (sys_rst) begin
            state <= systolic_pkg::feed_idle;
            step  <= '0;
        end else begin
            case (state)
                systolic_pkg::feed_idle: begin
                    step <= '0;
                    if (start) begin
                        state <= systolic_pkg::feed_run;
                    end
                end
                systolic_pkg::feed_run: begin
                    step <= step + 1'b1;
                    if (step == 2'd3) begin
                        state <= systolic_pkg::feed_flush;
                    end
                end
                systolic_pkg::feed_flush: begin
                    step <= step + 1'b1;
                    if (step == 2'd3) begin
                        state <= systolic_pkg::feed_idle;
                    end
                end
                default: begin
                    state <= systolic_pkg::feed_idle;
                end
            endcase
        end
    end

    // cycle count since leaving idle, 0 to 7
    assign t      = {state == systolic_pkg::feed_flush, step};
    assign active = (state != systolic_pkg::feed_idle);

    // k is the element index presented on a lane this cycle
    always_comb begin
        int k;
        feed.cal_en   = '0;
        feed.cal_done = '0;
        feed.v_data   = '0;
        feed.h_data   = '0;
        for (int n = 0; n < systolic_pkg::array_n; n++) begin
            k = int'(t) - n;
            if (active && k >= 0 && k < systolic_pkg::array_n) begin
                feed.cal_en[n] = 1'b1;
                feed.v_data[n] = mat_b[k[1:0]][n];
                feed.h_data[n] = mat_a[n][k[1:0]];
            end
            if (active && k == systolic_pkg::array_n) begin
                feed.cal_done[n] = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/apb_regs.sv
//##############################
// APB3 slave, no wait states, pready tied high
// A and B writable only while idle, C read-only
// pslverr on unmapped, unaligned or illegal accesses
// matrix words sit in the low 16 bits
//##############################
`timescale 1ns/1ps
`default_nettype none

module apb_regs (
    input  wire logic                   clk,
    input  wire logic                   sys_rst,
    input  wire systolic_pkg::apb_addr_t paddr,
    input  wire logic                   psel,
    input  wire logic                   penable,
    input  wire logic                   pwrite,
    input  wire logic [31:0]            pwdata,
    output logic [31:0]                 prdata,
    output logic                        pready,
    output logic                        pslverr,
    output systolic_pkg::matrix_t       mat_a,
    output systolic_pkg::matrix_t       mat_b,
    input  wire systolic_pkg::matrix_t  mat_c,
    output logic                        start,
    input  wire logic                   run_done
);

    logic busy;
    logic done;
    logic access;
    logic aligned;
    logic in_a;
    logic in_b;
    logic in_c;
    logic is_ctrl;
    logic is_status;
    logic mapped;
    logic bad_write;
    logic wr_ok;
    logic go;
    systolic_pkg::idx_t row;
    systolic_pkg::idx_t col;

    // address decode, each matrix occupies 64 bytes
    assign access    = psel && penable;
    assign aligned   = (paddr[1:0] == 2'b00);
    assign in_a      = aligned && (paddr[11:6] == systolic_pkg::a_base[11:6]);
    assign in_b      = aligned && (paddr[11:6] == systolic_pkg::b_base[11:6]);
    assign in_c      = aligned && (paddr[11:6] == systolic_pkg::c_base[11:6]);
    assign is_ctrl   = (paddr == systolic_pkg::ctrl_addr);
    assign is_status = (paddr == systolic_pkg::status_addr);
    assign mapped    = in_a || in_b || in_c || is_ctrl || is_status;
    assign row       = paddr[5:4];
    assign col       = paddr[3:2];

    // C and status are read-only, A, B and ctrl are locked during a run
    assign bad_write = pwrite && (in_c || is_status || (busy && (in_a || in_b || is_ctrl)));
    assign pslverr   = access && (!mapped || bad_write);
    assign wr_ok     = access && pwrite && mapped && !bad_write;
    assign go        = wr_ok && is_ctrl && pwdata[0];
    assign pready    = 1'b1;

    always_ff @(posedge clk) begin
        if (wr_ok && in_a) begin
            mat_a[row][col] <= pwdata[systolic_pkg::data_w-1:0];
        end
        if (wr_ok && in_b) begin
            mat_b[row][col] <= pwdata[systolic_pkg::data_w-1:0];
        end
    end

    // busy from start until the drain reports, done held until next start
    always_ff @(posedge clk) begin
        if (sys_rst) begin
            start <= 1'b0;
            busy  <= 1'b0;
            done  <= 1'b0;
        end else begin
            start <= go;
            if (go) begin
                busy <= 1'b1;
                done <= 1'b0;
            end else if (run_done) begin
                busy <= 1'b0;
                done <= 1'b1;
            end
        end
    end

    always_comb begin
        prdata = '0;
        if (in_a) begin
            prdata[systolic_pkg::data_w-1:0] = mat_a[row][col];
        end else if (in_b) begin
            prdata[systolic_pkg::data_w-1:0] = mat_b[row][col];
        end else if (in_c) begin
            prdata[systolic_pkg::data_w-1:0] = mat_c[row][col];
        end else if (is_status) begin
            prdata[1:0] = {done, busy};
        end
    end

endmodule

`default_nettype wire

// File: common/operand_if.sv
//##############################
// skewed operands and strobes from the feeder to the array
// cal_en, cal_done and v_data are indexed by column
// h_data is indexed by row
//##############################
`timescale 1ns/1ps
`default_nettype none

interface operand_if;

    logic [systolic_pkg::array_n-1:0] cal_en;
    logic [systolic_pkg::array_n-1:0] cal_done;
    systolic_pkg::data_t [systolic_pkg::array_n-1:0] v_data;
    systolic_pkg::data_t [systolic_pkg::array_n-1:0] h_data;

    modport src (
        output cal_en,
        output cal_done,
        output v_data,
        output h_data
    );

    modport sink (
        input cal_en,
        input cal_done,
        input v_data,
        input h_data
    );

endinterface

`default_nettype wire

// File: common/systolic_pkg.sv
//##############################
// shared sizes, types and APB map for the systolic multiplier
// matrices are square, array_n by array_n, stored row-major
// all arithmetic is unsigned and wraps at data_w bits
//##############################
`default_nettype none

package systolic_pkg;

    localparam int array_n = 4;
    localparam int data_w  = 16;

    typedef logic [data_w-1:0] data_t;
    typedef data_t [array_n-1:0][array_n-1:0] matrix_t;
    typedef logic [1:0] idx_t;
    typedef logic [11:0] apb_addr_t;

    // byte addresses, one 32-bit word per element
    localparam apb_addr_t a_base      = 12'h000;
    localparam apb_addr_t b_base      = 12'h040;
    localparam apb_addr_t c_base      = 12'h080;
    localparam apb_addr_t ctrl_addr   = 12'h0C0;
    localparam apb_addr_t status_addr = 12'h0C4;

    typedef enum logic [1:0] {
        feed_idle,
        feed_run,
        feed_flush
    } feed_state_t;

endpackage

`default_nettype wire
